//--- tb.f
+incdir+hw
hw/albuf_bus_pkg.sv
hw/albuf_isa_pkg.sv
hw/albuf_rd_if.sv
hw/resp_fifo.sv
hw/boundary_counter.sv
hw/fetch_ctrl.sv
hw/instr_aligner.sv
hw/alignment_buffer.sv
verif/tb_clk_gen.sv
verif/tb_alignment_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the alignment buffer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_alignment_buffer \
  -f tb.f \
  -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished without error"
exit 0

//--- verif/tb_alignment_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the instruction alignment buffer
// Memory and prefetcher model, reference decoder, compare tasks,
// directed tests and watchdog
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

module tb_alignment_buffer;
  timeunit 1ns;
  timeprecision 100ps;
  import albuf_bus_pkg::*;
  import albuf_isa_pkg::*;

  localparam int MEM_WORDS       = 64;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic                    clk, rst_n;
  logic                    instr_req, pc_set, kill_if, fetch_ready, instr_ready;
  logic                    resp_valid, resp_err;
  instr_addr_t             branch_addr, fetch_addr, instr_addr;
  fetch_word_t             resp_rdata;
  logic                    fetch_valid, fetch_branch, instr_valid, instr_err;
  logic                    prefetch_busy;
  instr_t                  instr_rdata;
  logic [`ALBUF_PTR_W-1:0] outstnd_cnt;

  // Memory image and in-order response queue
  fetch_word_t mem_word [MEM_WORDS];
  logic        mem_err [MEM_WORDS];
  fetch_resp_t pend_resp [$];
  int          pend_due [$];

  integer      seed;
  int          cycle, emitted, acc_cnt, done_cnt;
  instr_addr_t fetch_ptr, exp_addr, stall_addr;
  logic        stall_q;

  tb_clk_gen #(.HALF_PERIOD(4), .RST_CYCLES(4)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  alignment_buffer UUT (
    .clk (clk), .rst_n (rst_n),
    .instr_req_i (instr_req), .pc_set_i (pc_set), .kill_if_i (kill_if),
    .branch_addr_i (branch_addr),
    .fetch_valid_o (fetch_valid), .fetch_branch_o (fetch_branch),
    .fetch_addr_o (fetch_addr), .fetch_ready_i (fetch_ready),
    .resp_valid_i (resp_valid), .resp_err_i (resp_err), .resp_rdata_i (resp_rdata),
    .instr_valid_o (instr_valid), .instr_rdata_o (instr_rdata),
    .instr_addr_o (instr_addr), .instr_err_o (instr_err), .instr_ready_i (instr_ready),
    .prefetch_busy_o (prefetch_busy), .outstnd_cnt_o (outstnd_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "instruction mismatch");
    end
  endtask

  task automatic check_addr(input string name, input instr_addr_t got, input instr_addr_t exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_count(input string name, input logic [`ALBUF_PTR_W-1:0] got,
                             input logic [`ALBUF_PTR_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "count mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////
  function automatic half_t mem_half(input instr_addr_t a);
    fetch_word_t w;
    w = mem_word[int'(a[7:2])];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic mem_err_at(input instr_addr_t a);
    return mem_err[int'(a[7:2])];
  endfunction

  // Mode 0 gives only 32-bit instructions, mode 1 a random parcel mix
  task automatic fill_mem(input int mode);
    instr_addr_t a;
    logic [31:0] r;
    for (int i = 0; i < MEM_WORDS; i++) begin
      a = instr_addr_t'(i * 4);
      r = $random(seed);
      if (mode == 0) begin
        mem_word[i] = {a[15:0] ^ a[31:16] ^ 16'h9e37, a[15:2], 2'b11};
      end else begin
        // Low bits 11 about half the time, so splits are frequent
        mem_word[i][15:0]  = {a[15:2] ^ r[15:2], r[0] ? 2'b11 : {1'b0, r[1]}};
        mem_word[i][31:16] = {a[31:18] ^ r[31:18], r[16] ? 2'b11 : {1'b0, r[17]}};
      end
      mem_err[i] = 1'b0;
    end
  endtask

  // Accepted request answered 1 to 3 cycles later, in order
  task automatic push_request();
    fetch_resp_t r;
    r.rdata = mem_word[int'(fetch_ptr[7:2])];
    r.err   = mem_err[int'(fetch_ptr[7:2])];
    pend_resp.push_back(r);
    pend_due.push_back(cycle + 1 + int'($unsigned($random(seed)) % 3));
    fetch_ptr = fetch_ptr + instr_addr_t'(4);
  endtask

  task automatic drive_resp();
    fetch_resp_t r;
    if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
      r = pend_resp.pop_front();
      void'(pend_due.pop_front());
      resp_valid = 1'b1;
      resp_rdata = r.rdata;
      resp_err   = r.err;
    end else begin
      resp_valid = 1'b0;
      resp_rdata = '0;
      resp_err   = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference decoder and per-cycle monitor
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_emit();
    half_t lo, hi;
    logic  exp_e;
    lo = mem_half(exp_addr);
    check_addr("instr_addr_o", instr_addr, exp_addr);
    if (lo[1:0] != 2'b11) begin
      // Compressed, upper half is don't care
      check_instr("instr_rdata_o", {16'h0, instr_rdata[15:0]}, {16'h0, lo});
      exp_e    = mem_err_at(exp_addr);
      exp_addr = exp_addr + instr_addr_t'(2);
    end else begin
      hi = mem_half(exp_addr + instr_addr_t'(2));
      check_instr("instr_rdata_o", instr_rdata, {hi, lo});
      exp_e    = mem_err_at(exp_addr) | mem_err_at(exp_addr + instr_addr_t'(2));
      exp_addr = exp_addr + instr_addr_t'(4);
    end
    check_flag("instr_err_o", instr_err, exp_e);
    emitted++;
  endtask

  // Sampled at the falling edge where all outputs are settled
  task automatic observe();
    check_count("outstnd_cnt_o", outstnd_cnt, (`ALBUF_PTR_W)'(acc_cnt - done_cnt));
    if (acc_cnt - done_cnt > `ALBUF_MAX_OUTSTND) begin
      $display("More than two fetch requests outstanding at %0d ns", $time);
      $display("Result: FAILED");
      $fatal(1, "outstanding limit");
    end
    // Busy while any request is still in flight
    if (acc_cnt != done_cnt) begin
      check_flag("prefetch_busy_o", prefetch_busy, 1'b1);
    end
    // Stalled output must hold its instruction
    if (stall_q && !pc_set && !kill_if) begin
      check_flag("instr_valid_o", instr_valid, 1'b1);
      check_addr("instr_addr_o", instr_addr, stall_addr);
    end
    stall_q    = instr_valid && !instr_ready && !kill_if;
    stall_addr = instr_addr;
    // Branch strobe follows the redirect in the same cycle
    check_flag("fetch_branch_o", fetch_branch, pc_set);
    if (pc_set) begin
      check_addr("fetch_addr_o", fetch_addr, {branch_addr[31:1], 1'b0});
      fetch_ptr = {branch_addr[31:2], 2'b00};
      exp_addr  = {branch_addr[31:1], 1'b0};
    end
    if (kill_if) begin
      check_flag("instr_valid_o", instr_valid, 1'b0);
    end
    if (fetch_valid && fetch_ready) begin
      push_request();
      acc_cnt++;
    end
    if (resp_valid) begin
      done_cnt++;
    end
    if (instr_valid && instr_ready) begin
      check_emit();
    end
  endtask

  // One clock cycle, inputs change 1 ns after the rising edge
  task automatic tick();
    @(negedge clk);
    observe();
    @(posedge clk);
    cycle++;
    #1;
    drive_resp();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic do_branch(input instr_addr_t a);
    pc_set      = 1'b1;
    kill_if     = 1'b1;
    branch_addr = a;
    instr_req   = 1'b1;
    tick();
    pc_set  = 1'b0;
    kill_if = 1'b0;
  endtask

  task automatic run_until(input int n);
    int start;
    start = emitted;
    while (emitted - start < n) begin
      tick();
    end
  endtask

  // Drop the request and wait for the in-flight responses
  task automatic drain();
    instr_req = 1'b0;
    tick();
    while (acc_cnt != done_cnt || pend_due.size() != 0) begin
      tick();
    end
    check_flag("prefetch_busy_o", prefetch_busy, 1'b0);
    check_count("outstnd_cnt_o", outstnd_cnt, '0);
  endtask

  task automatic wait_in_flight();
    while (pend_due.size() == 0) begin
      tick();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_aligned_32();
    fill_mem(0);
    do_branch(32'h0000_0040);
    run_until(12);
    drain();
  endtask

  task automatic test_mixed_unaligned();
    fill_mem(1);
    do_branch(32'h0000_001a);
    run_until(30);
    drain();
  endtask

  task automatic test_bus_error();
    fill_mem(1);
    // Compressed parcels at 0x86 and 0x88 and a split over words 34 and 35
    mem_word[33][17:16] = 2'b01;
    mem_word[34][1:0]   = 2'b00;
    mem_word[34][17:16] = 2'b11;
    // Compressed parcels at 0x8e and 0x90 and a split over words 36 and 37
    mem_word[35][17:16] = 2'b10;
    mem_word[36][1:0]   = 2'b01;
    mem_word[36][17:16] = 2'b11;
    // Error on the first word of one split and on the second word of the other
    mem_err[34] = 1'b1;
    mem_err[37] = 1'b1;
    do_branch(32'h0000_0086);
    run_until(24);
    drain();
  endtask

  task automatic test_backpressure();
    int start;
    fill_mem(1);
    do_branch(32'h0000_0002);
    start = emitted;
    while (emitted - start < 30) begin
      instr_ready = ($unsigned($random(seed)) % 3) != 0;
      tick();
    end
    instr_ready = 1'b1;
    drain();
  endtask

  task automatic test_redirect();
    fill_mem(1);
    do_branch(32'h0000_0010);
    run_until(5);
    // Redirect with responses still in flight
    wait_in_flight();
    do_branch(32'h0000_00c6);
    run_until(10);
    wait_in_flight();
    do_branch(32'h0000_0030);
    run_until(8);
    drain();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    instr_req   = 1'b0;
    pc_set      = 1'b0;
    kill_if     = 1'b0;
    branch_addr = '0;
    fetch_ready = 1'b1;
    resp_valid  = 1'b0;
    resp_err    = 1'b0;
    resp_rdata  = '0;
    instr_ready = 1'b1;
    seed        = 32'h8326_b2a5;
    cycle       = 0;
    emitted     = 0;
    acc_cnt     = 0;
    done_cnt    = 0;
    stall_q     = 1'b0;
    fetch_ptr   = '0;
    exp_addr    = '0;
    stall_addr  = '0;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    // Idle state after reset
    check_flag("fetch_valid_o", fetch_valid, 1'b0);
    check_flag("instr_valid_o", instr_valid, 1'b0);
    check_flag("prefetch_busy_o", prefetch_busy, 1'b0);
    check_count("outstnd_cnt_o", outstnd_cnt, '0);
    check_addr("instr_addr_o", instr_addr, '0);
    test_aligned_32();
    test_mixed_unaligned();
    test_bus_error();
    test_backpressure();
    test_redirect();
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog expired, the tests did not finish in %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- verif/tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
// Free running clock, active low reset held for a few cycles
////////////////////////////////////////////////////////////////////////////
module tb_clk_gen #(
  parameter int HALF_PERIOD = 4,
  parameter int RST_CYCLES  = 4
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release reset just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- hw/alignment_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Instruction alignment buffer top level
// Fetch control, response FIFO, boundary counter and aligner
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

module alignment_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  // Core control
  input  logic                       instr_req_i,
  input  logic                       pc_set_i,
  input  logic                       kill_if_i,
  input  albuf_isa_pkg::instr_addr_t branch_addr_i,
  // Prefetcher requests
  output logic                       fetch_valid_o,
  output logic                       fetch_branch_o,
  output albuf_isa_pkg::instr_addr_t fetch_addr_o,
  input  logic                       fetch_ready_i,
  // Prefetcher responses
  input  logic                       resp_valid_i,
  input  logic                       resp_err_i,
  input  albuf_bus_pkg::fetch_word_t resp_rdata_i,
  // Instructions out
  output logic                       instr_valid_o,
  output albuf_isa_pkg::instr_t      instr_rdata_o,
  output albuf_isa_pkg::instr_addr_t instr_addr_o,
  output logic                       instr_err_o,
  input  logic                       instr_ready_i,
  // Status
  output logic                       prefetch_busy_o,
  output logic [`ALBUF_PTR_W-1:0]    outstnd_cnt_o
);
  import albuf_bus_pkg::*;

  fetch_resp_t                resp;
  logic                       resp_accept;
  logic                       emit;
  logic [`ALBUF_ICNT_W-1:0]   avail_cnt;

  albuf_rd_if rd_if ();

  assign resp = '{rdata: resp_rdata_i, err: resp_err_i};

  // Redirect goes out with the halfword-aligned target
  assign fetch_branch_o = pc_set_i;
  assign fetch_addr_o   = {branch_addr_i[31:1], 1'b0};

  fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .pc_set_i        (pc_set_i),
    .kill_if_i       (kill_if_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .avail_cnt_i     (avail_cnt),
    .fetch_valid_o   (fetch_valid_o),
    .resp_accept_o   (resp_accept),
    .prefetch_busy_o (prefetch_busy_o),
    .outstnd_cnt_o   (outstnd_cnt_o)
  );

  // FIFO and boundary counter both see the gated stream
  resp_fifo u_resp_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .resp_accept_i (resp_accept),
    .resp_i        (resp),
    .rd            (rd_if.fifo)
  );

  boundary_counter u_boundary_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_if_i     (kill_if_i),
    .resp_accept_i (resp_accept),
    .emit_i        (emit),
    .branch_addr_i (branch_addr_i),
    .resp_rdata_i  (resp_rdata_i),
    .avail_cnt_o   (avail_cnt)
  );

  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_if_i     (kill_if_i),
    .instr_ready_i (instr_ready_i),
    .branch_addr_i (branch_addr_i),
    .rd            (rd_if.aligner),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o),
    .emit_o        (emit)
  );

endmodule

//--- hw/instr_aligner.sv
////////////////////////////////////////////////////////////////////////////
// Instruction aligner
// Builds 16-bit and 32-bit instructions from the FIFO head,
// merges bus errors and holds the instruction address
////////////////////////////////////////////////////////////////////////////
module instr_aligner (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pc_set_i,
  input  logic                       kill_if_i,
  input  logic                       instr_ready_i,
  input  albuf_isa_pkg::instr_addr_t branch_addr_i,
  albuf_rd_if.aligner                rd,
  output logic                       instr_valid_o,
  output albuf_isa_pkg::instr_t      instr_rdata_o,
  output albuf_isa_pkg::instr_addr_t instr_addr_o,
  output logic                       instr_err_o,
  output logic                       emit_o
);
  import albuf_bus_pkg::*;
  import albuf_isa_pkg::*;

  instr_addr_t addr_q;
  fetch_resp_t head_w, nxt_w;
  half_t       head_lo, head_hi, nxt_lo;
  logic        unaligned;
  // Instruction at addr_q is compressed
  logic        comp;
  logic        parts_valid;

  assign head_w    = rd.head_resp;
  assign nxt_w     = rd.next_resp;
  assign head_lo   = head_w.rdata[15:0];
  assign head_hi   = head_w.rdata[31:16];
  assign nxt_lo    = nxt_w.rdata[15:0];
  assign unaligned = addr_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // Instruction select
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (unaligned) begin
      comp          = head_hi[1:0] != 2'b11;
      instr_rdata_o = {nxt_lo, head_hi};
      // Split instruction needs the second word too
      parts_valid   = comp ? rd.head_valid : rd.next_valid;
      instr_err_o   = comp ? head_w.err : (head_w.err || nxt_w.err);
    end else begin
      // Whole instruction in the head word
      comp          = head_lo[1:0] != 2'b11;
      instr_rdata_o = head_w.rdata;
      parts_valid   = rd.head_valid;
      instr_err_o   = head_w.err;
    end
  end

  assign instr_valid_o = parts_valid && !kill_if_i;
  assign emit_o        = instr_valid_o && instr_ready_i;

  // Head word stays while its upper half is still unread
  assign rd.advance = emit_o && (unaligned || !comp);
  assign rd.clear   = kill_if_i;

  assign instr_addr_o = addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      addr_q <= {branch_addr_i[31:1], 1'b0};
    end else if (emit_o) begin
      addr_q <= addr_q + (comp ? instr_addr_t'(2) : instr_addr_t'(4));
    end
  end

endmodule

//--- hw/fetch_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Fetch request control
// Outstanding transaction count, flush count for stale responses,
// response gating and request decision
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

module fetch_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     instr_req_i,
  input  logic                     pc_set_i,
  input  logic                     kill_if_i,
  input  logic                     fetch_ready_i,
  input  logic                     resp_valid_i,
  input  logic [`ALBUF_ICNT_W-1:0] avail_cnt_i,
  output logic                     fetch_valid_o,
  output logic                     resp_accept_o,
  output logic                     prefetch_busy_o,
  output logic [`ALBUF_PTR_W-1:0]  outstnd_cnt_o
);

  localparam int PTR_W  = `ALBUF_PTR_W;
  localparam int ICNT_W = `ALBUF_ICNT_W;

  logic [PTR_W-1:0] outstnd_q;
  // Responses still to be dropped after a redirect
  logic [PTR_W-1:0] flush_q;
  logic             req_accepted;

  // Stale responses never reach the buffer
  assign resp_accept_o = resp_valid_i && (flush_q == '0);

  // Request when the buffer runs low, or on a redirect
  assign fetch_valid_o = instr_req_i &&
                         (outstnd_q < PTR_W'(`ALBUF_MAX_OUTSTND)) &&
                         ((avail_cnt_i == '0) ||
                          ((avail_cnt_i == ICNT_W'(1)) && (outstnd_q == '0)) ||
                          pc_set_i);

  assign req_accepted    = fetch_valid_o && fetch_ready_i;
  assign prefetch_busy_o = (outstnd_q != '0) || fetch_valid_o;
  assign outstnd_cnt_o   = outstnd_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstnd_q <= '0;
      flush_q   <= '0;
    end else begin
      // Up on accepted request, down on any response
      if (req_accepted && !resp_valid_i) begin
        outstnd_q <= outstnd_q + PTR_W'(1);
      end else if (!req_accepted && resp_valid_i) begin
        outstnd_q <= outstnd_q - PTR_W'(1);
      end

      // Response arriving with the kill counts as consumed
      if (pc_set_i) begin
        flush_q <= outstnd_q - PTR_W'(kill_if_i && resp_valid_i);
      end else if (resp_valid_i && (flush_q != '0)) begin
        flush_q <= flush_q - PTR_W'(1);
      end
    end
  end

endmodule

//--- hw/boundary_counter.sv
////////////////////////////////////////////////////////////////////////////
// Instruction boundary tracking on the write side of the buffer
// Aligned and complete flags, instruction ends per incoming word,
// count of complete instructions buffered
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

module boundary_counter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pc_set_i,
  input  logic                       kill_if_i,
  input  logic                       resp_accept_i,
  input  logic                       emit_i,
  input  albuf_isa_pkg::instr_addr_t branch_addr_i,
  input  albuf_bus_pkg::fetch_word_t resp_rdata_i,
  output logic [`ALBUF_ICNT_W-1:0]   avail_cnt_o
);
  import albuf_isa_pkg::*;

  localparam int ICNT_W = `ALBUF_ICNT_W;

  half_t             lo_half, hi_half;
  logic              lo_comp, hi_comp;
  // Next word starts on a word boundary
  logic              aligned_q, aligned_nxt;
  // No 32-bit instruction is waiting for its upper half
  logic              complete_q, complete_nxt;
  logic [1:0]        n_ends;
  logic [ICNT_W-1:0] icnt_q;
  // Instruction emitted last cycle
  logic              pop_q;

  assign lo_half = resp_rdata_i[15:0];
  assign hi_half = resp_rdata_i[31:16];
  assign lo_comp = lo_half[1:0] != 2'b11;
  assign hi_comp = hi_half[1:0] != 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // Classify each accepted word
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    aligned_nxt  = aligned_q;
    complete_nxt = complete_q;
    n_ends       = 2'd0;
    if (pc_set_i) begin
      // Unaligned and complete only after an unaligned branch
      // The low half of the first word is then skipped
      aligned_nxt  = !branch_addr_i[1];
      complete_nxt = branch_addr_i[1];
    end else if (resp_accept_i) begin
      if (aligned_q && !lo_comp) begin
        // Whole 32-bit instruction, flags unchanged
        n_ends = 2'd1;
      end else begin
        // Low half ends a compressed or a split instruction
        // unless it is skipped after a branch
        n_ends = {1'b0, aligned_q || !complete_q} + {1'b0, hi_comp};
        // Uncompressed upper half leaves a split instruction open
        aligned_nxt  = hi_comp;
        complete_nxt = hi_comp;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aligned_q  <= 1'b0;
      complete_q <= 1'b0;
      icnt_q     <= '0;
      pop_q      <= 1'b0;
    end else begin
      aligned_q  <= aligned_nxt;
      complete_q <= complete_nxt;
      pop_q      <= emit_i;
      // Emissions come off one cycle late
      if (kill_if_i) begin
        icnt_q <= '0;
      end else begin
        icnt_q <= icnt_q + ICNT_W'(n_ends) - ICNT_W'(pop_q);
      end
    end
  end

  // Correct for the pop not yet taken off
  assign avail_cnt_o = icnt_q - ICNT_W'(pop_q);

endmodule

//--- hw/resp_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Response FIFO of the alignment buffer
// Circular word storage with per-entry valid bits
// Head and next entries with pass-through of the arriving response
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

module resp_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pc_set_i,
  input  logic                       resp_accept_i,
  input  albuf_bus_pkg::fetch_resp_t resp_i,
  albuf_rd_if.fifo                   rd
);
  import albuf_bus_pkg::*;

  localparam int DEPTH = `ALBUF_DEPTH;
  localparam int PTR_W = `ALBUF_PTR_W;

  fetch_resp_t      mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q, valid_nxt;
  logic [PTR_W-1:0] rptr_q, wptr_q;
  logic [PTR_W-1:0] rptr_inc, wptr_inc;
  logic             head_stored, next_stored;

  // Step a pointer, wrap after the last entry
  function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign rptr_inc    = ptr_step(rptr_q);
  assign wptr_inc    = ptr_step(wptr_q);
  assign head_stored = valid_q[rptr_q];
  assign next_stored = valid_q[rptr_inc];

  // Empty slot is filled by the word arriving now
  // Words are contiguous from rptr, so the write pointer sits there
  assign rd.head_resp  = head_stored ? mem_q[rptr_q] : resp_i;
  assign rd.head_valid = head_stored || resp_accept_i;
  assign rd.next_resp  = next_stored ? mem_q[rptr_inc] : resp_i;
  assign rd.next_valid = next_stored || (head_stored && resp_accept_i);

  // Push before pop
  // A word passed straight through never stays valid
  always_comb begin
    valid_nxt = valid_q;
    if (resp_accept_i) begin
      valid_nxt[wptr_q] = 1'b1;
    end
    if (rd.advance) begin
      valid_nxt[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_accept_i) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
    end else if (rd.clear || pc_set_i) begin
      // New stream starts from an empty buffer
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
    end else begin
      valid_q <= valid_nxt;
      if (resp_accept_i) begin
        wptr_q <= wptr_inc;
      end
      if (rd.advance) begin
        rptr_q <= rptr_inc;
      end
    end
  end

endmodule

//--- hw/albuf_rd_if.sv
////////////////////////////////////////////////////////////////////////////
// Read port between the response FIFO and the instruction aligner
// Head and next entries, pop and clear controls
////////////////////////////////////////////////////////////////////////////
interface albuf_rd_if;
  import albuf_bus_pkg::*;

  // Entry at the read pointer
  fetch_resp_t head_resp;
  logic        head_valid;

  // Entry one past the read pointer
  fetch_resp_t next_resp;
  logic        next_valid;

  // Pop the head word
  logic        advance;
  // Drop all words and rewind the pointers
  logic        clear;

  modport fifo (
    output head_resp, head_valid, next_resp, next_valid,
    input  advance, clear
  );

  modport aligner (
    input  head_resp, head_valid, next_resp, next_valid,
    output advance, clear
  );

endinterface

//--- hw/albuf_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Instruction-side types of the alignment buffer
// Instruction address, 16-bit parcel and whole instruction
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

package albuf_isa_pkg;

  // Byte address of an instruction
  // Bit 0 is always zero
  typedef logic [`ALBUF_XLEN-1:0] instr_addr_t;

  // One 16-bit instruction parcel
  typedef logic [15:0] half_t;

  // Whole instruction
  // A compressed one sits in [15:0], upper half don't care
  typedef logic [`ALBUF_XLEN-1:0] instr_t;

  // Compressed rule
  // A parcel is compressed unless its two low bits are both one
  // Each module applies this check on its own parcels

endpackage

//--- hw/albuf_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Bus-side types of the alignment buffer
// Fetch word and fetch response, the response is also one FIFO entry
////////////////////////////////////////////////////////////////////////////
`include "albuf_cfg.svh"

package albuf_bus_pkg;

  // One word as returned by the prefetcher
  typedef logic [`ALBUF_XLEN-1:0] fetch_word_t;

  // Fetch response
  // Stored as is in the FIFO
  typedef struct packed {
    fetch_word_t rdata;
    logic        err;
  } fetch_resp_t;

endpackage

//--- hw/albuf_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Alignment buffer configuration macros
// FIFO depth and pointer width, instruction counter width,
// outstanding request limit and bus word width
////////////////////////////////////////////////////////////////////////////
`ifndef ALBUF_CFG_SVH
`define ALBUF_CFG_SVH

// Words held in the response FIFO
`define ALBUF_DEPTH 3
// Read and write pointer width
`define ALBUF_PTR_W 2
// Up to two instructions per word, so one bit wider than a pointer
`define ALBUF_ICNT_W (`ALBUF_PTR_W + 1)
// Requests allowed in flight towards the prefetcher
`define ALBUF_MAX_OUTSTND 2
// Bus word width
`define ALBUF_XLEN 32

`endif
